// ==== rtl/rv32_ex_pkg.sv ====
// RV32I execute stage package
// Shared widths, major opcode encodings, ALU operation codes
// and the wrong-path squash state
`default_nettype none

package rv32_ex_pkg;

  localparam int XLEN   = 32;  // Data and address width
  localparam int REG_AW = 5;   // Register index width

  // Major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011
  } opcode_t;

  // ALU operations
  typedef enum logic [4:0] {
    ADD      = 5'd0,   // Also load/store address
    SUB      = 5'd1,
    SLL      = 5'd2,
    SLT      = 5'd3,
    SLTU     = 5'd4,
    XOR      = 5'd5,
    SRL      = 5'd6,
    SRA      = 5'd7,
    OR       = 5'd8,
    AND      = 5'd9,
    PASS_IMM = 5'd10,  // LUI
    PC_IMM   = 5'd11,  // AUIPC
    LINK     = 5'd12,  // JAL, pc+4 and pc+imm target
    JALR_TGT = 5'd13,  // JALR, pc+4 and (a+imm)&~1 target
    BEQ      = 5'd14,
    BNE      = 5'd15,
    BLT      = 5'd16,
    BGE      = 5'd17,
    BLTU     = 5'd18,
    BGEU     = 5'd19
  } alu_op_t;

  // Wrong-path squash state after a redirect
  typedef enum logic {
    SQ_RUN  = 1'b0,  // Normal flow
    SQ_WAIT = 1'b1   // Dropping until pc hits target
  } sq_state_t;

endpackage

`default_nettype wire

// ==== rtl/ex_decode.sv ====
// Execute stage decoder
// Turns the raw RV32I word into an ALU operation, a sign-extended
// immediate and the write/memory/control flags, all registered.
// Unknown opcodes and branch funct3 codes give an invalid slot.
`timescale 1ns/100ps
`default_nettype none

module ex_decode
(
  input  wire                               i_clk,
  input  wire                               i_arst_n,
  input  wire                               i_valid,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_instr,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_pc,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_rs1_val,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_rs2_val,
  output logic                              o_valid,
  output rv32_ex_pkg::alu_op_t              o_op,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_pc,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_a,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_b,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_imm,
  output logic                              o_use_imm,
  output logic [rv32_ex_pkg::REG_AW-1:0]    o_rd,
  output logic                              o_reg_write,
  output logic                              o_mem_read,
  output logic                              o_mem_write,
  output logic                              o_is_ctrl
);

  import rv32_ex_pkg::*;

  opcode_t            opcode;
  logic [2:0]         funct3;
  logic [REG_AW-1:0]  rd;
  logic [XLEN-1:0]    imm_i;
  logic [XLEN-1:0]    imm_s;
  logic [XLEN-1:0]    imm_b;
  logic [XLEN-1:0]    imm_u;
  logic [XLEN-1:0]    imm_j;
  logic [XLEN-1:0]    imm_sh;
  logic               known;    // Legal opcode/funct3
  alu_op_t            op;
  logic [XLEN-1:0]    imm;
  logic               use_imm;
  logic               reg_wr;
  logic               mem_rd;
  logic               mem_wr;
  logic               is_ctrl;
  logic               slot_ok;  // Valid and decodable

  assign opcode = opcode_t'(i_instr[6:0]);
  assign funct3 = i_instr[14:12];
  assign rd     = i_instr[11:7];

  assign imm_i  = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s  = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b  = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                   i_instr[11:8], 1'b0};                        // Byte offset
  assign imm_u  = {i_instr[31:12], 12'b0};
  assign imm_j  = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                   i_instr[30:21], 1'b0};                       // Byte offset
  assign imm_sh = {{(XLEN-5){1'b0}}, i_instr[24:20]};           // 5-bit shamt

  always_comb
  begin
    known   = 1'b1;
    op      = ADD;
    imm     = imm_i;
    use_imm = 1'b0;
    reg_wr  = 1'b0;
    mem_rd  = 1'b0;
    mem_wr  = 1'b0;
    is_ctrl = 1'b0;
    case (opcode)
      LUI:
      begin
        op     = PASS_IMM;
        imm    = imm_u;
        reg_wr = 1'b1;
      end
      AUIPC:
      begin
        op     = PC_IMM;
        imm    = imm_u;
        reg_wr = 1'b1;
      end
      JAL:
      begin
        op      = LINK;
        imm     = imm_j;
        reg_wr  = 1'b1;
        is_ctrl = 1'b1;
      end
      JALR:
      begin
        op      = JALR_TGT;
        use_imm = 1'b1;                                         // Target from a+imm
        reg_wr  = 1'b1;
        is_ctrl = 1'b1;
      end
      BRANCH:
      begin
        imm     = imm_b;
        is_ctrl = 1'b1;                                         // Compares a with b
        case (funct3)
          3'd0:    op = BEQ;
          3'd1:    op = BNE;
          3'd4:    op = BLT;
          3'd5:    op = BGE;
          3'd6:    op = BLTU;
          3'd7:    op = BGEU;
          default: known = 1'b0;                                // funct3 2/3 reserved
        endcase
      end
      LOAD:
      begin
        use_imm = 1'b1;                                         // Address a+imm
        reg_wr  = 1'b1;
        mem_rd  = 1'b1;
      end
      STORE:
      begin
        imm     = imm_s;
        use_imm = 1'b1;
        mem_wr  = 1'b1;
      end
      OP_IMM, OP:
      begin
        use_imm = (opcode == OP_IMM);
        reg_wr  = 1'b1;
        case (funct3)
          3'd0:    op = (opcode == OP && i_instr[30]) ? SUB : ADD;  // No SUBI
          3'd1:    op = SLL;
          3'd2:    op = SLT;
          3'd3:    op = SLTU;
          3'd4:    op = XOR;
          3'd5:    op = i_instr[30] ? SRA : SRL;
          3'd6:    op = OR;
          default: op = AND;
        endcase
        if (opcode == OP_IMM && (funct3 == 3'd1 || funct3 == 3'd5))
          imm = imm_sh;                                         // Drop funct7 bits
      end
      default: known = 1'b0;
    endcase
  end

  assign slot_ok = i_valid & known;

  // Control flags
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_valid     <= 1'b0;
      o_reg_write <= 1'b0;
      o_mem_read  <= 1'b0;
      o_mem_write <= 1'b0;
      o_is_ctrl   <= 1'b0;
    end
    else
    begin
      o_valid     <= slot_ok;
      o_reg_write <= slot_ok & reg_wr & (rd != '0);             // x0 never written
      o_mem_read  <= slot_ok & mem_rd;
      o_mem_write <= slot_ok & mem_wr;
      o_is_ctrl   <= slot_ok & is_ctrl;
    end
  end

  // Payload, held when no input
  always_ff @(posedge i_clk)
  begin
    if (i_valid)
    begin
      o_op      <= op;
      o_pc      <= i_pc;
      o_a       <= i_rs1_val;
      o_b       <= i_rs2_val;
      o_imm     <= imm;
      o_use_imm <= use_imm;
      o_rd      <= rd;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ex_alu.sv ====
// Execute stage ALU
// Combinational arithmetic/logic unit, branch comparator and
// jump/branch target adder for RV32I
`timescale 1ns/100ps
`default_nettype none

module ex_alu
(
  input  rv32_ex_pkg::alu_op_t              i_op,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_pc,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_a,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_b,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_imm,
  input  wire                               i_use_imm,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_result,
  output logic                              o_taken,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_target
);

  import rv32_ex_pkg::*;

  logic [XLEN-1:0] opb;       // Second operand
  logic [4:0]      shamt;
  logic [XLEN-1:0] sum;       // a + opb
  logic [XLEN-1:0] pc_imm;
  logic [XLEN-1:0] pc_plus4;
  logic            lt_op;     // Signed a < opb
  logic            ltu_op;    // Unsigned a < opb
  logic            br_eq;
  logic            br_lt;
  logic            br_ltu;

  assign opb      = i_use_imm ? i_imm : i_b;
  assign shamt    = opb[4:0];
  assign sum      = i_a + opb;
  assign pc_imm   = i_pc + i_imm;
  assign pc_plus4 = i_pc + XLEN'(4);

  assign lt_op    = $signed(i_a) < $signed(opb);
  assign ltu_op   = i_a < opb;

  // Branches always compare the two registers
  assign br_eq    = i_a == i_b;
  assign br_lt    = $signed(i_a) < $signed(i_b);
  assign br_ltu   = i_a < i_b;

  always_comb
  begin
    o_result = sum;
    o_taken  = 1'b0;
    o_target = pc_imm;                                      // Branch and JAL target
    case (i_op)
      ADD:      o_result = sum;                             // Also load/store address
      SUB:      o_result = i_a - opb;
      SLL:      o_result = i_a << shamt;
      SLT:      o_result = {{(XLEN-1){1'b0}}, lt_op};
      SLTU:     o_result = {{(XLEN-1){1'b0}}, ltu_op};
      XOR:      o_result = i_a ^ opb;
      SRL:      o_result = i_a >> shamt;
      SRA:      o_result = $unsigned($signed(i_a) >>> shamt);  // Sign fills
      OR:       o_result = i_a | opb;
      AND:      o_result = i_a & opb;
      PASS_IMM: o_result = i_imm;
      PC_IMM:   o_result = pc_imm;
      LINK:
      begin
        o_result = pc_plus4;                                // Return address
        o_taken  = 1'b1;
      end
      JALR_TGT:
      begin
        o_result = pc_plus4;
        o_taken  = 1'b1;
        o_target = {sum[XLEN-1:1], 1'b0};                   // Clear bit 0
      end
      BEQ:
      begin
        o_result = pc_imm;
        o_taken  = br_eq;
      end
      BNE:
      begin
        o_result = pc_imm;
        o_taken  = !br_eq;
      end
      BLT:
      begin
        o_result = pc_imm;
        o_taken  = br_lt;
      end
      BGE:
      begin
        o_result = pc_imm;
        o_taken  = !br_lt;
      end
      BLTU:
      begin
        o_result = pc_imm;
        o_taken  = br_ltu;
      end
      BGEU:
      begin
        o_result = pc_imm;
        o_taken  = !br_ltu;
      end
      default:  o_result = sum;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/ex_result.sv ====
// EX/MEM result stage
// Registers the execute result record, raises a one-cycle redirect
// for taken control transfers and squashes wrong-path slots until
// the redirect target pc shows up
`timescale 1ns/100ps
`default_nettype none

module ex_result
(
  input  wire                               i_clk,
  input  wire                               i_arst_n,
  input  wire                               i_valid,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_pc,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_result,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_store_data,
  input  wire  [rv32_ex_pkg::REG_AW-1:0]    i_rd,
  input  wire                               i_reg_write,
  input  wire                               i_mem_read,
  input  wire                               i_mem_write,
  input  wire                               i_is_ctrl,
  input  wire                               i_taken,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_target,
  output logic                              o_valid,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_pc,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_result,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_store_data,
  output logic [rv32_ex_pkg::REG_AW-1:0]    o_rd,
  output logic                              o_reg_write,
  output logic                              o_mem_read,
  output logic                              o_mem_write,
  output logic                              o_redirect,
  output logic [rv32_ex_pkg::XLEN-1:0]      o_redirect_pc
);

  import rv32_ex_pkg::*;

  sq_state_t       sq_state;
  logic [XLEN-1:0] sq_target;     // Pc we are waiting for
  logic            squash;        // Wrong-path slot
  logic            keep;          // Slot goes out
  logic            redirect_now;

  assign squash       = (sq_state == SQ_WAIT) && (i_pc != sq_target);
  assign keep         = i_valid && !squash;
  assign redirect_now = keep && i_is_ctrl && i_taken;

  // Target register doubles as redirect pc, loaded on the same edge
  assign o_redirect_pc = sq_target;

  // Squash FSM
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      sq_state <= SQ_RUN;
    else if (redirect_now)
      sq_state <= SQ_WAIT;            // Includes a taken jump at the target
    else if (keep)
      sq_state <= SQ_RUN;             // Target reached, or already running
  end

  always_ff @(posedge i_clk)
  begin
    if (redirect_now)
      sq_target <= i_target;
  end

  // Record flags and redirect strobe
  always_ff @(posedge i_clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_valid     <= 1'b0;
      o_reg_write <= 1'b0;
      o_mem_read  <= 1'b0;
      o_mem_write <= 1'b0;
      o_redirect  <= 1'b0;
    end
    else
    begin
      o_valid     <= keep;
      o_reg_write <= keep & i_reg_write;
      o_mem_read  <= keep & i_mem_read;
      o_mem_write <= keep & i_mem_write;
      o_redirect  <= redirect_now;    // One cycle, with its own o_valid
    end
  end

  // Record payload
  always_ff @(posedge i_clk)
  begin
    o_pc         <= i_pc;
    o_result     <= i_result;
    o_store_data <= i_store_data;
    o_rd         <= i_rd;
  end

endmodule

`default_nettype wire

// ==== rtl/rv32_ex_top.sv ====
// RV32I execute stage top
// Decode register, combinational ALU and EX/MEM result register.
// Two-cycle latency from input strobe to o_valid.
`timescale 1ns/100ps
`default_nettype none

module rv32_ex_top
(
  input  wire                               i_clk,
  input  wire                               i_arst_n,
  input  wire                               i_valid,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_instr,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_pc,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_rs1_val,
  input  wire  [rv32_ex_pkg::XLEN-1:0]      i_rs2_val,
  output wire                               o_valid,
  output wire  [rv32_ex_pkg::XLEN-1:0]      o_pc,
  output wire  [rv32_ex_pkg::XLEN-1:0]      o_result,
  output wire  [rv32_ex_pkg::XLEN-1:0]      o_store_data,
  output wire  [rv32_ex_pkg::REG_AW-1:0]    o_rd,
  output wire                               o_reg_write,
  output wire                               o_mem_read,
  output wire                               o_mem_write,
  output wire                               o_redirect,
  output wire  [rv32_ex_pkg::XLEN-1:0]      o_redirect_pc
);

  import rv32_ex_pkg::*;

  // Decode stage registers
  wire                d_valid;
  alu_op_t            d_op;
  wire   [XLEN-1:0]   d_pc;
  wire   [XLEN-1:0]   d_a;
  wire   [XLEN-1:0]   d_b;            // Also store data
  wire   [XLEN-1:0]   d_imm;
  wire                d_use_imm;
  wire   [REG_AW-1:0] d_rd;
  wire                d_reg_write;
  wire                d_mem_read;
  wire                d_mem_write;
  wire                d_is_ctrl;

  // ALU outputs
  wire   [XLEN-1:0]   a_result;
  wire                a_taken;
  wire   [XLEN-1:0]   a_target;

  ex_decode u_decode
  (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_valid     (i_valid),
    .i_instr     (i_instr),
    .i_pc        (i_pc),
    .i_rs1_val   (i_rs1_val),
    .i_rs2_val   (i_rs2_val),
    .o_valid     (d_valid),
    .o_op        (d_op),
    .o_pc        (d_pc),
    .o_a         (d_a),
    .o_b         (d_b),
    .o_imm       (d_imm),
    .o_use_imm   (d_use_imm),
    .o_rd        (d_rd),
    .o_reg_write (d_reg_write),
    .o_mem_read  (d_mem_read),
    .o_mem_write (d_mem_write),
    .o_is_ctrl   (d_is_ctrl)
  );

  ex_alu u_alu
  (
    .i_op        (d_op),
    .i_pc        (d_pc),
    .i_a         (d_a),
    .i_b         (d_b),
    .i_imm       (d_imm),
    .i_use_imm   (d_use_imm),
    .o_result    (a_result),
    .o_taken     (a_taken),
    .o_target    (a_target)
  );

  ex_result u_result
  (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_valid       (d_valid),
    .i_pc          (d_pc),
    .i_result      (a_result),
    .i_store_data  (d_b),
    .i_rd          (d_rd),
    .i_reg_write   (d_reg_write),
    .i_mem_read    (d_mem_read),
    .i_mem_write   (d_mem_write),
    .i_is_ctrl     (d_is_ctrl),
    .i_taken       (a_taken),
    .i_target      (a_target),
    .o_valid       (o_valid),
    .o_pc          (o_pc),
    .o_result      (o_result),
    .o_store_data  (o_store_data),
    .o_rd          (o_rd),
    .o_reg_write   (o_reg_write),
    .o_mem_read    (o_mem_read),
    .o_mem_write   (o_mem_write),
    .o_redirect    (o_redirect),
    .o_redirect_pc (o_redirect_pc)
  );

endmodule

`default_nettype wire

// ==== include/rv32_ex_tb_table.svh ====
// Execute stage stimulus and expected-value table
// Columns: valid, random operands, pc, instruction, rs1, rs2, kept,
// result, rd, flags {reg_write, mem_read, mem_write, redirect}, redirect pc.
// Random rows get rs1/rs2 from $random and the result from the reference
// model. Kept low marks an idle slot or a wrong-path slot after a redirect
`ifndef RV32_EX_TB_TABLE_SVH
`define RV32_EX_TB_TABLE_SVH

task automatic load_rows();
  add_row(1, 1, 'h100, enc_r(0, 0, 3), 0, 0, 1, 0, 3, 4'b1000, 0);         // ADD
  add_row(1, 1, 'h104, enc_r(1, 0, 4), 0, 0, 1, 0, 4, 4'b1000, 0);         // SUB
  add_row(1, 1, 'h108, enc_r(0, 1, 5), 0, 0, 1, 0, 5, 4'b1000, 0);         // SLL
  add_row(1, 1, 'h10C, enc_r(0, 2, 6), 0, 0, 1, 0, 6, 4'b1000, 0);         // SLT
  add_row(1, 1, 'h110, enc_r(0, 3, 7), 0, 0, 1, 0, 7, 4'b1000, 0);         // SLTU
  add_row(1, 1, 'h114, enc_r(0, 4, 8), 0, 0, 1, 0, 8, 4'b1000, 0);         // XOR
  add_row(1, 1, 'h118, enc_r(0, 5, 9), 0, 0, 1, 0, 9, 4'b1000, 0);         // SRL
  add_row(1, 1, 'h11C, enc_r(1, 5, 10), 0, 0, 1, 0, 10, 4'b1000, 0);       // SRA
  add_row(1, 1, 'h120, enc_r(0, 6, 11), 0, 0, 1, 0, 11, 4'b1000, 0);       // OR
  add_row(1, 1, 'h124, enc_r(0, 7, 12), 0, 0, 1, 0, 12, 4'b1000, 0);       // AND
  add_row(1, 0, 'h128, enc_r(1, 0, 3), 5, 7, 1, 'hFFFFFFFE, 3, 4'b1000, 0);
  add_row(1, 0, 'h12C, enc_r(1, 5, 4), 'h80000010, 4, 1, 'hF8000001, 4, 4'b1000, 0);
  add_row(1, 0, 'h130, enc_r(0, 2, 5), 'hFFFFFFFF, 1, 1, 1, 5, 4'b1000, 0);  // -1 < 1
  add_row(1, 0, 'h134, enc_r(0, 3, 6), 'hFFFFFFFF, 1, 1, 0, 6, 4'b1000, 0);  // Big unsigned
  add_row(1, 0, 'h138, enc_i('h403, 5, 7, OP_IMM), 'hFFFFFF00, 0, 1, 'hFFFFFFE0, 7,
          4'b1000, 0);                                                     // SRAI 3
  add_row(1, 0, 'h13C, enc_i('h004, 1, 8, OP_IMM), 'hF1, 0, 1, 'hF10, 8, 4'b1000, 0);
  add_row(1, 0, 'h140, enc_i('hFFF, 0, 9, OP_IMM), 10, 0, 1, 9, 9, 4'b1000, 0);
  add_row(1, 0, 'h144, enc_i('hFFF, 3, 10, OP_IMM), 5, 0, 1, 1, 10, 4'b1000, 0);
  add_row(1, 0, 'h148, enc_r(0, 0, 0), 1, 2, 1, 3, 0, 4'b0000, 0);         // rd x0
  add_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 4'b0000, 0);                          // Idle slot
  add_row(1, 1, 'h14C, enc_i('h5A5, 4, 11, OP_IMM), 0, 0, 1, 0, 11, 4'b1000, 0);
  add_row(1, 1, 'h150, enc_i('hF0F, 7, 12, OP_IMM), 0, 0, 1, 0, 12, 4'b1000, 0);
  add_row(1, 1, 'h154, enc_i('h01F, 5, 13, OP_IMM), 0, 0, 1, 0, 13, 4'b1000, 0);
  add_row(1, 1, 'h158, enc_i('h41F, 5, 14, OP_IMM), 0, 0, 1, 0, 14, 4'b1000, 0);
  add_row(1, 0, 'h15C, enc_u('hABCDE, 14, LUI), 0, 0, 1, 'hABCDE000, 14, 4'b1000, 0);
  add_row(1, 0, 'h160, enc_u('h00001, 15, AUIPC), 0, 0, 1, 'h1160, 15, 4'b1000, 0);
  add_row(1, 0, 'h164, enc_i('hFFC, 2, 16, LOAD), 'h1000, 0, 1, 'hFFC, 16, 4'b1100, 0);
  add_row(1, 0, 'h168, enc_s('h010, 2), 'h2000, 'hDEADBEEF, 1, 'h2010, 0, 4'b0010, 0);
  add_row(1, 0, 'h16C, enc_b('h10, 0), 1, 2, 1, 0, 0, 4'b0000, 0);          // BEQ not taken
  add_row(1, 0, 'h170, enc_b('h8, 0), 7, 7, 1, 0, 0, 4'b0001, 'h178);       // BEQ taken
  add_row(1, 0, 'h174, enc_r(0, 0, 3), 1, 2, 0, 0, 0, 4'b0000, 0);          // Wrong path
  add_row(1, 0, 'h178, enc_b('h10, 1), 3, 3, 1, 0, 0, 4'b0000, 0);          // BNE
  add_row(1, 0, 'h17C, enc_b('h4, 1), 3, 4, 1, 0, 0, 4'b0001, 'h180);
  add_row(1, 0, 'h180, enc_b('h10, 4), 5, 'hFFFFFFFF, 1, 0, 0, 4'b0000, 0);  // BLT
  add_row(1, 0, 'h184, enc_b('h4, 4), 'hFFFFFFFF, 5, 1, 0, 0, 4'b0001, 'h188);
  add_row(1, 0, 'h188, enc_b('h10, 5), 'hFFFFFFFF, 5, 1, 0, 0, 4'b0000, 0);  // BGE
  add_row(1, 0, 'h18C, enc_b('h4, 5), 5, 5, 1, 0, 0, 4'b0001, 'h190);
  add_row(1, 0, 'h190, enc_b('h10, 6), 'hFFFFFFFF, 5, 1, 0, 0, 4'b0000, 0);  // BLTU
  add_row(1, 0, 'h194, enc_b('h4, 6), 5, 'hFFFFFFFF, 1, 0, 0, 4'b0001, 'h198);
  add_row(1, 0, 'h198, enc_b('h10, 7), 5, 'hFFFFFFFF, 1, 0, 0, 4'b0000, 0);  // BGEU
  add_row(1, 0, 'h19C, enc_b('h1FF8, 7), 'hFFFFFFFF, 5, 1, 0, 0, 4'b0001, 'h194);
  add_row(1, 0, 'h1A0, enc_r(0, 0, 3), 1, 2, 0, 0, 0, 4'b0000, 0);          // Wrong path
  add_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 4'b0000, 0);
  add_row(1, 0, 'h1A4, enc_i('h001, 0, 3, OP_IMM), 1, 0, 0, 0, 0, 4'b0000, 0);
  add_row(1, 0, 'h194, enc_j('h10, 1), 0, 0, 1, 'h198, 1, 4'b1001, 'h1A4);   // JAL at target
  add_row(1, 0, 'h198, enc_r(0, 0, 3), 1, 2, 0, 0, 0, 4'b0000, 0);
  add_row(1, 0, 'h1A4, enc_i('h005, 0, 2, JALR), 'h300, 0, 1, 'h1A8, 2, 4'b1001, 'h304);
  add_row(1, 0, 'h304, enc_i('h001, 0, 3, OP_IMM), 41, 0, 1, 42, 3, 4'b1000, 0);
  add_row(1, 1, 'h308, enc_r(0, 0, 4), 0, 0, 1, 0, 4, 4'b1000, 0);
endtask

`endif

// ==== verification/tb_rv32_ex.sv ====
// Testbench for the RV32I execute stage
// Drives a table of instructions, queues the expected EX/MEM records
// and checks every output slot, redirect and wrong-path squash
`timescale 1ns/100ps
`default_nettype none

module tb_rv32_ex;

  import rv32_ex_pkg::*;

  localparam int DRAIN_MAX = 20;  // Cycles allowed to empty the queue

  typedef struct packed {
    logic            valid;
    logic            rnd;         // Operands from $random
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic            kept;        // Must appear on o_valid
    logic [XLEN-1:0] result;
    logic [4:0]      rd;
    logic [3:0]      flags;       // reg_write, mem_read, mem_write, redirect
    logic [XLEN-1:0] rpc;
  } row_t;

  logic              i_clk;
  logic              i_arst_n;
  logic              i_valid;
  logic [XLEN-1:0]   i_instr;
  logic [XLEN-1:0]   i_pc;
  logic [XLEN-1:0]   i_rs1_val;
  logic [XLEN-1:0]   i_rs2_val;
  wire               o_valid;
  wire  [XLEN-1:0]   o_pc;
  wire  [XLEN-1:0]   o_result;
  wire  [XLEN-1:0]   o_store_data;
  wire  [REG_AW-1:0] o_rd;
  wire               o_reg_write;
  wire               o_mem_read;
  wire               o_mem_write;
  wire               o_redirect;
  wire  [XLEN-1:0]   o_redirect_pc;

  row_t   rows[$];
  row_t   expq[$];                // Expected records in order
  int     dueq[$];                // Cycle each record is due
  int     cyc = 0;
  integer seed;

  rv32_ex_top DUT
  (
    .i_clk (i_clk), .i_arst_n (i_arst_n), .i_valid (i_valid), .i_instr (i_instr),
    .i_pc (i_pc), .i_rs1_val (i_rs1_val), .i_rs2_val (i_rs2_val),
    .o_valid (o_valid), .o_pc (o_pc), .o_result (o_result), .o_store_data (o_store_data),
    .o_rd (o_rd), .o_reg_write (o_reg_write), .o_mem_read (o_mem_read),
    .o_mem_write (o_mem_write), .o_redirect (o_redirect), .o_redirect_pc (o_redirect_pc)
  );

  always #10 i_clk = ~i_clk;      // 20 ns period

  always @(posedge i_clk)
    cyc <= cyc + 1;

  // RV32I encoders with rs1 = x1 and rs2 = x2 in every word
  function automatic logic [XLEN-1:0] enc_r(input logic alt, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, rd, 7'h33};
  endfunction

  function automatic logic [XLEN-1:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
  endfunction

  function automatic logic [XLEN-1:0] enc_s(input logic [11:0] imm, input logic [2:0] f3);
    return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [XLEN-1:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [XLEN-1:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                            input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [XLEN-1:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  // Reference result for OP and OP_IMM words
  function automatic logic [XLEN-1:0] ref_alu(input logic [XLEN-1:0] instr,
                                              input logic [XLEN-1:0] a,
                                              input logic [XLEN-1:0] b);
    logic [XLEN-1:0] opnd;
    logic [4:0]      sh;
    logic            alt;           // Bit 30 selects SUB and SRA
    opnd = (instr[6:0] == 7'h13) ? {{20{instr[31]}}, instr[31:20]} : b;
    sh   = opnd[4:0];
    alt  = instr[30];
    case (instr[14:12])
      3'd0:    return (alt && instr[6:0] == 7'h33) ? a - opnd : a + opnd;
      3'd1:    return a << sh;
      3'd2:    return ($signed(a) < $signed(opnd)) ? 1 : 0;
      3'd3:    return (a < opnd) ? 1 : 0;
      3'd4:    return a ^ opnd;
      3'd5:    return (a >> sh) | ((alt && a[XLEN-1]) ? ~({XLEN{1'b1}} >> sh) : '0);
      3'd6:    return a | opnd;
      default: return a & opnd;
    endcase
  endfunction

  task automatic add_row(input logic v, input logic rnd, input logic [XLEN-1:0] pc,
                         input logic [XLEN-1:0] instr, input logic [XLEN-1:0] rs1,
                         input logic [XLEN-1:0] rs2, input logic kept,
                         input logic [XLEN-1:0] result, input logic [4:0] rd,
                         input logic [3:0] flags, input logic [XLEN-1:0] rpc);
    rows.push_back({v, rnd, pc, instr, rs1, rs2, kept, result, rd, flags, rpc});
  endtask

  `include "rv32_ex_tb_table.svh"

  task automatic abort_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [XLEN-1:0] exp,
                                 input logic [XLEN-1:0] act);
    $display("FAILED at %0t: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
    $display("Test failed");
    $fatal(1);
  endtask

  // Scoreboard sampled mid-cycle
  always @(negedge i_clk)
  begin
    row_t e;
    int   due;
    if (i_arst_n === 1'b1)          // Only once reset is released
    begin
      if (o_valid)
      begin
        assert (expq.size() != 0) else abort_run("o_valid high with no record expected");
        e   = expq.pop_front();
        due = dueq.pop_front();
        assert (due == cyc) else report_mismatch("output cycle", XLEN'(due), XLEN'(cyc));
        assert (o_pc == e.pc) else report_mismatch("o_pc", e.pc, o_pc);
        assert (o_reg_write == e.flags[3])
          else report_mismatch("o_reg_write", XLEN'(e.flags[3]), XLEN'(o_reg_write));
        assert (o_mem_read == e.flags[2])
          else report_mismatch("o_mem_read", XLEN'(e.flags[2]), XLEN'(o_mem_read));
        assert (o_mem_write == e.flags[1])
          else report_mismatch("o_mem_write", XLEN'(e.flags[1]), XLEN'(o_mem_write));
        assert (o_redirect == e.flags[0])
          else report_mismatch("o_redirect", XLEN'(e.flags[0]), XLEN'(o_redirect));
        if (e.flags[3:1] != 3'b000)   // Value, link or address
          assert (o_result == e.result)
            else report_mismatch("o_result", e.result, o_result);
        if (e.flags[3])
          assert (o_rd == e.rd) else report_mismatch("o_rd", XLEN'(e.rd), XLEN'(o_rd));
        if (e.flags[1])
          assert (o_store_data == e.rs2)
            else report_mismatch("o_store_data", e.rs2, o_store_data);
        if (e.flags[0])
          assert (o_redirect_pc == e.rpc)
            else report_mismatch("o_redirect_pc", e.rpc, o_redirect_pc);
      end
      else
      begin
        assert (!o_redirect && !o_reg_write && !o_mem_read && !o_mem_write)
          else abort_run("side-effect flag high in an empty output slot");
        if (dueq.size() != 0)
          assert (dueq[0] != cyc) else abort_run("expected record missing on o_valid");
      end
    end
  end

  initial
  begin
    row_t r;
    int   wait_cnt;
    seed      = 21;
    i_clk     = 1'b0;
    i_arst_n  = 1'b0;
    i_valid   = 1'b0;
    i_instr   = '0;
    i_pc      = '0;
    i_rs1_val = '0;
    i_rs2_val = '0;
    load_rows();
    repeat (8) @(posedge i_clk);
    i_arst_n <= 1'b1;
    @(posedge i_clk);                                     // Quiet cycle before first input
    for (int k = 0; k < rows.size(); k++)
    begin
      @(posedge i_clk);
      r = rows[k];
      if (r.rnd)
      begin
        r.rs1    = $random(seed);
        r.rs2    = $random(seed);
        r.result = ref_alu(r.instr, r.rs1, r.rs2);
      end
      i_valid   <= r.valid;
      i_pc      <= r.pc;
      i_instr   <= r.instr;
      i_rs1_val <= r.rs1;
      i_rs2_val <= r.rs2;
      if (r.valid && r.kept)
      begin
        expq.push_back(r);
        dueq.push_back(cyc + 3);                          // Sampled next edge and out 2 later
      end
    end
    @(posedge i_clk);
    i_valid  <= 1'b0;
    wait_cnt = 0;
    while (expq.size() != 0 && wait_cnt < DRAIN_MAX)
    begin
      @(posedge i_clk);
      wait_cnt++;
    end
    if (expq.size() == 0)
    begin
      $display("Test passed");
      $finish;
    end
    else
    begin
      $display("Timeout: %0d expected records never left the DUT", expq.size());
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// ==== rv32_ex.f ====
+incdir+include
rtl/rv32_ex_pkg.sv
rtl/ex_decode.sv
rtl/ex_alu.sv
rtl/ex_result.sv
rtl/rv32_ex_top.sv
verification/tb_rv32_ex.sv

// ==== Makefile ====
# Verilator build and run for the RV32I execute stage testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_rv32_ex
FILELIST  ?= rv32_ex.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test passed

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Run, keep a log, then look for the pass line in it
run: compile
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
